// File: mini_core.f
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/register_file.sv
logic/alu.sv
logic/writeback_unit.sv
logic/mini_core.sv
verification/mini_core_tb.sv

// File: verification/mini_core_tb.sv
`timescale 1ns/1ps

module mini_core_tb import rv_isa_pkg::*; import core_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int N_SEED     = 62;
  localparam int N_RAND     = 64;
  localparam int N_STORE    = 32;
  localparam int PROG_LEN   = N_SEED + N_RAND + N_STORE;
  localparam int DLY_N      = 256;
  localparam int WATCHDOG_CYCLES = 40 * PROG_LEN + 200;

  logic   clk;
  logic   rst_ni;
  logic   instr_req_o;
  addr_t  instr_addr_o;
  logic   instr_gnt_i;
  logic   instr_rvalid_i;
  instr_t instr_rdata_i;
  logic   data_req_o;
  addr_t  data_addr_o;
  word_t  data_wdata_o;
  logic   data_gnt_i;
  logic   data_rvalid_i;

  int          seed;
  logic        stim_ready;
  instr_t      prog [PROG_LEN];
  int unsigned igrant_dly [DLY_N];
  int unsigned irsp_dly [DLY_N];
  int unsigned dgrant_dly [DLY_N];
  int unsigned dack_dly [DLY_N];

  // Expected and observed stores, in program order
  addr_t exp_addr [$];
  word_t exp_data [$];
  addr_t got_addr [$];
  word_t got_data [$];
  int    n_logged;

  mini_core DUT (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  //////////////////////////////
  // Failure handling and checks
  //////////////////////////////

  task automatic end_with_failure();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%h, actual 0x%h", name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%h, actual 0x%h", name, expected, actual);
      end_with_failure();
    end
  endtask

  //////////////////////////////
  // Instruction encoders
  //////////////////////////////

  function automatic instr_t encode_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                      logic [2:0] f3, reg_addr_t rd, opcode_t opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t encode_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                      reg_addr_t rd, opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t encode_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                      logic [2:0] f3, opcode_t opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic instr_t encode_u(logic [19:0] imm, reg_addr_t rd, opcode_t opc);
    return {imm, rd, opc};
  endfunction

  function automatic int unsigned pick_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Seed all registers, random ALU mix, then store every register
  function automatic void build_stimulus();
    int          idx;
    int          k;
    int unsigned kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   prev_rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    idx = 0;
    for (k = 1; k < 32; k++) begin
      prog[idx]     = encode_u(20'($random(seed)), reg_addr_t'(k), OPC_LUI);
      prog[idx + 1] = encode_i(12'($random(seed)), reg_addr_t'(k), F3_ADD_SUB,
                               reg_addr_t'(k), OPC_OP_IMM);
      idx += 2;
    end
    prev_rd = 5'd1;
    for (k = 0; k < N_RAND; k++) begin
      rd   = reg_addr_t'(pick_below(32));
      // Half the time read the previous result right away
      rs1  = (pick_below(2) != 0) ? prev_rd : reg_addr_t'(pick_below(32));
      rs2  = reg_addr_t'(pick_below(32));
      f3   = 3'(pick_below(8));
      kind = pick_below(16);
      if (kind < 7) begin
        f7 = ((f3 == F3_ADD_SUB || f3 == F3_SR) && pick_below(2) != 0) ? F7_ALT : 7'd0;
        prog[idx] = encode_r(f7, rs2, rs1, f3, rd, OPC_OP);
      end else if (kind < 14) begin
        imm = 12'($random(seed));
        // Shift immediates keep funct7 in the top bits
        if (f3 == F3_SLL) begin
          imm[11:5] = 7'd0;
        end else if (f3 == F3_SR) begin
          imm[11:5] = (pick_below(2) != 0) ? F7_ALT : 7'd0;
        end
        prog[idx] = encode_i(imm, rs1, f3, rd, OPC_OP_IMM);
      end else if (kind < 15) begin
        prog[idx] = encode_u(20'($random(seed)), rd, OPC_LUI);
      end else begin
        // MUL encoding, outside the supported set
        prog[idx] = encode_r(7'b0000001, rs2, rs1, f3, rd, OPC_OP);
      end
      prev_rd = rd;
      idx++;
    end
    // Negative S immediates off x0, distinct addresses
    for (k = 0; k < N_STORE; k++) begin
      prog[idx] = encode_s(12'h800 + 12'(k * 8), reg_addr_t'(k), 5'd0, F3_SW, OPC_STORE);
      idx++;
    end
    for (k = 0; k < DLY_N; k++) begin
      igrant_dly[k] = pick_below(4);
      irsp_dly[k]   = 1 + pick_below(2);
      dgrant_dly[k] = pick_below(4);
      dack_dly[k]   = 1 + pick_below(3);
    end
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      F3_ADD_SUB: return alt ? a - b : a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:     return a ^ b;
      F3_SR:      return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  function automatic void run_reference();
    word_t      regs [32];
    instr_t     ins;
    word_t      a;
    word_t      b;
    word_t      res;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       we;
    int         i;
    for (i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (i = 0; i < PROG_LEN; i++) begin
      ins = prog[i];
      f3  = ins[14:12];
      f7  = ins[31:25];
      a   = regs[ins[19:15]];
      b   = regs[ins[24:20]];
      we  = 1'b0;
      res = '0;
      case (ins[6:0])
        OPC_LUI: begin
          res = {ins[31:12], 12'd0};
          we  = 1'b1;
        end
        OPC_OP_IMM: begin
          b   = {{20{ins[31]}}, ins[31:20]};
          we  = (f3 == F3_SLL) ? (f7 == 7'd0) :
                (f3 == F3_SR) ? (f7 == 7'd0 || f7 == F7_ALT) : 1'b1;
          res = ref_alu(f3, f3 == F3_SR && f7 == F7_ALT, a, b);
        end
        OPC_OP: begin
          we  = (f7 == 7'd0) || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SR));
          res = ref_alu(f3, f7 == F7_ALT, a, b);
        end
        OPC_STORE: begin
          if (f3 == F3_SW) begin
            exp_addr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
            exp_data.push_back(b);
          end
        end
        default: ;
      endcase
      // x0 stays zero
      if (we && ins[11:7] != 5'd0) begin
        regs[ins[11:7]] = res;
      end
    end
  endfunction

  function automatic instr_t prog_word(addr_t addr);
    if (addr[1:0] == 2'b00 && (addr >> 2) < PROG_LEN) begin
      return prog[addr >> 2];
    end
    return INSTR_NOP;
  endfunction

  //////////////////////////////
  // Reset and first fetch
  //////////////////////////////

  initial begin
    rst_ni     = 1'b0;
    stim_ready = 1'b0;
    n_logged   = 0;
    seed       = 32'hd6709d80;
    build_stimulus();
    run_reference();
    stim_ready = 1'b1;
    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    @(negedge clk);
    if (data_req_o !== 1'b0) begin
      $display("data_req_o is active in the first cycle after reset");
      end_with_failure();
    end
    if (instr_req_o !== 1'b1) begin
      $display("No instruction request in the first cycle after reset");
      end_with_failure();
    end
    check_addr("instr_addr_o", BOOT_ADDR, instr_addr_o);
  end

  // Instruction memory, random grant and response delays
  initial begin : instr_memory
    int     gnt_wait;
    int     rsp_wait;
    int     n_gnt;
    logic   waiting;
    addr_t  held_addr;
    addr_t  next_addr;
    instr_t rsp_word;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = INSTR_NOP;
    rsp_wait       = 0;
    n_gnt          = 0;
    waiting        = 1'b0;
    next_addr      = BOOT_ADDR;
    wait (stim_ready);
    gnt_wait = igrant_dly[0];
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      instr_gnt_i    = (gnt_wait == 0);
      instr_rvalid_i = 1'b0;
      if (rsp_wait > 0) begin
        rsp_wait--;
        if (rsp_wait == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = rsp_word;
        end
      end
      // Settled mid cycle
      @(negedge clk);
      if (rst_ni && instr_req_o) begin
        if (waiting) begin
          check_addr("instr_addr_o", held_addr, instr_addr_o);
        end
        if (instr_gnt_i) begin
          check_addr("instr_addr_o", next_addr, instr_addr_o);
          rsp_word = prog_word(instr_addr_o);
          n_gnt++;
          rsp_wait  = irsp_dly[n_gnt % DLY_N];
          gnt_wait  = igrant_dly[n_gnt % DLY_N];
          next_addr = next_addr + INSTR_BYTES;
          waiting   = 1'b0;
        end else begin
          waiting   = 1'b1;
          held_addr = instr_addr_o;
          if (gnt_wait > 0) begin
            gnt_wait--;
          end
        end
      end else begin
        waiting = 1'b0;
      end
    end
  end

  // Data memory, logs every granted store
  initial begin : data_memory
    int    gnt_wait;
    int    ack_wait;
    logic  waiting;
    addr_t held_addr;
    word_t held_data;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    ack_wait      = 0;
    waiting       = 1'b0;
    wait (stim_ready);
    gnt_wait = dgrant_dly[0];
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      data_gnt_i    = (gnt_wait == 0);
      data_rvalid_i = 1'b0;
      if (ack_wait > 0) begin
        ack_wait--;
        data_rvalid_i = (ack_wait == 0);
      end
      @(negedge clk);
      if (rst_ni) begin
        // Request held with stable payload until grant
        if (waiting) begin
          if (data_req_o !== 1'b1) begin
            $display("data_req_o dropped before its grant");
            end_with_failure();
          end
          check_addr("data_addr_o", held_addr, data_addr_o);
          check_word("data_wdata_o", held_data, data_wdata_o);
        end
        waiting = 1'b0;
        if (data_req_o && data_gnt_i) begin
          got_addr.push_back(data_addr_o);
          got_data.push_back(data_wdata_o);
          n_logged++;
          ack_wait = dack_dly[n_logged % DLY_N];
          gnt_wait = dgrant_dly[n_logged % DLY_N];
        end else if (data_req_o) begin
          waiting   = 1'b1;
          held_addr = data_addr_o;
          held_data = data_wdata_o;
          if (gnt_wait > 0) begin
            gnt_wait--;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Store comparison
  //////////////////////////////

  initial begin : compare_stores
    int i;
    wait (stim_ready);
    for (i = 0; i < exp_addr.size(); i++) begin
      wait (n_logged > i);
      check_addr("data_addr_o", exp_addr[i], got_addr[i]);
      check_word("data_wdata_o", exp_data[i], got_data[i]);
    end
    // Quiet period to catch a duplicated store
    repeat (20) @(posedge clk);
    if (n_logged != exp_addr.size()) begin
      $display("Saw %0d stores but the program has %0d", n_logged, exp_addr.size());
      end_with_failure();
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d stores seen", WATCHDOG_CYCLES, n_logged);
    end_with_failure();
  end

endmodule

// File: logic/mini_core.sv
`timescale 1ns/1ps

module mini_core import rv_isa_pkg::*; import core_pkg::*; (
  input  logic   clk,
  input  logic   rst_ni,
  // Instruction memory port
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  // Data memory port
  output logic   data_req_o,
  output addr_t  data_addr_o,
  output word_t  data_wdata_o,
  input  logic   data_gnt_i,
  input  logic   data_rvalid_i
);

  // Fetch to decode
  logic      fetch_valid;
  instr_t    fetch_instr;
  logic      decode_ready;

  // Register file ports
  reg_addr_t rs1_addr, rs2_addr;
  word_t     rs1_data, rs2_data;
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  // Decode to execute
  logic      ex_valid;
  ex_op_t    ex_op;
  logic      ex_ready;
  word_t     alu_result;

  //////////////////////////////
  // Stages
  //////////////////////////////

  fetch_unit fetch_unit_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .fetch_valid_o  (fetch_valid),
    .fetch_instr_o  (fetch_instr),
    .decode_ready_i (decode_ready)
  );

  decoder decoder_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .fetch_valid_i  (fetch_valid),
    .fetch_instr_i  (fetch_instr),
    .decode_ready_o (decode_ready),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .ex_valid_o     (ex_valid),
    .ex_op_o        (ex_op),
    .ex_ready_i     (ex_ready)
  );

  register_file register_file_i (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_we_i    (wb_we),
    .wb_addr_i  (wb_addr),
    .wb_data_i  (wb_data)
  );

  alu alu_i (
    .ex_op_i  (ex_op),
    .result_o (alu_result)
  );

  writeback_unit writeback_unit_i (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .ex_valid_i    (ex_valid),
    .ex_op_i       (ex_op),
    .alu_result_i  (alu_result),
    .ex_ready_o    (ex_ready),
    .wb_we_o       (wb_we),
    .wb_addr_o     (wb_addr),
    .wb_data_o     (wb_data),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i)
  );

endmodule

// File: logic/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit import rv_isa_pkg::*; import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  // From execute
  input  logic      ex_valid_i,
  input  ex_op_t    ex_op_i,
  input  word_t     alu_result_i,
  output logic      ex_ready_o,
  // Register file write port
  output logic      wb_we_o,
  output reg_addr_t wb_addr_o,
  output word_t     wb_data_o,
  // Data memory port, writes only
  output logic      data_req_o,
  output addr_t     data_addr_o,
  output word_t     data_wdata_o,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i
);

  store_state_e state_q, state_d;
  addr_t        addr_q;
  word_t        wdata_q;
  logic         alu_retire;

  // ALU ops retire the cycle they arrive
  assign alu_retire = ex_valid_i && !ex_op_i.is_store;
  assign wb_we_o    = alu_retire && ex_op_i.rd_we;
  assign wb_addr_o  = ex_op_i.rd;
  assign wb_data_o  = alu_result_i;

  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  //////////////////////////////
  // Store FSM
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    data_req_o = 1'b0;
    ex_ready_o = alu_retire;
    case (state_q)
      ST_IDLE: begin
        if (ex_valid_i && ex_op_i.is_store) begin
          state_d = ST_REQ;
        end
      end
      ST_REQ: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        // Write acknowledge frees the stage
        if (data_rvalid_i) begin
          ex_ready_o = 1'b1;
          state_d    = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address and data held stable for the whole request
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && ex_valid_i && ex_op_i.is_store) begin
      addr_q  <= alu_result_i;
      wdata_q <= ex_op_i.store_data;
    end
  end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
  input  ex_op_t ex_op_i,
  output word_t  result_o
);

  word_t      a, b;
  word_t      b_add, sum;
  logic       is_sub;
  logic [4:0] shamt;
  logic       lt_s, lt_u;

  assign a     = ex_op_i.operand_a;
  assign b     = ex_op_i.operand_b;
  assign shamt = b[4:0];

  //////////////////////////////
  // Adder
  //////////////////////////////

  // Also forms the store address
  assign is_sub = (ex_op_i.alu_op == ALU_SUB);
  assign b_add  = is_sub ? ~b : b;
  assign sum    = a + b_add + word_t'(is_sub);

  // Comparisons for SLT and SLTU
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (ex_op_i.alu_op)
      ALU_ADD,
      ALU_SUB:  result_o = sum;
      ALU_AND:  result_o = a & b;
      ALU_OR:   result_o = a | b;
      ALU_XOR:  result_o = a ^ b;
      ALU_SLT:  result_o = word_t'(lt_s);
      ALU_SLTU: result_o = word_t'(lt_u);
      ALU_SLL:  result_o = a << shamt;
      ALU_SRL:  result_o = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  result_o = word_t'($signed(a) >>> shamt);
      default:  result_o = sum;
    endcase
  end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file import rv_isa_pkg::*; import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o,
  input  logic      wb_we_i,
  input  reg_addr_t wb_addr_i,
  input  word_t     wb_data_i
);

  // x1 to x31, x0 has no storage
  word_t regs_q [31:1];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_we_i && wb_addr_i != '0) begin
      regs_q[wb_addr_i] <= wb_data_i;
    end
  end

  // Same-cycle write forwards to the read ports
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                      (wb_we_i && wb_addr_i == rs1_addr_i) ? wb_data_i : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                      (wb_we_i && wb_addr_i == rs2_addr_i) ? wb_data_i : regs_q[rs2_addr_i];

endmodule

// File: logic/decoder.sv
`timescale 1ns/1ps

module decoder import rv_isa_pkg::*; import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  // From fetch
  input  logic      fetch_valid_i,
  input  instr_t    fetch_instr_i,
  output logic      decode_ready_o,
  // Register file read ports
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  // To execute
  output logic      ex_valid_o,
  output ex_op_t    ex_op_o,
  input  logic      ex_ready_i
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  word_t      imm_i, imm_s, imm_u;
  logic       f7_zero, f7_alt;
  logic       writes_rd;
  alu_op_e    f3_op;
  ex_op_t     op_d, op_q;
  logic       valid_q;

  //////////////////////////////
  // Field split
  //////////////////////////////

  assign opcode     = fetch_instr_i[6:0];
  assign rd         = fetch_instr_i[11:7];
  assign funct3     = fetch_instr_i[14:12];
  assign rs1_addr_o = fetch_instr_i[19:15];
  assign rs2_addr_o = fetch_instr_i[24:20];
  assign funct7     = fetch_instr_i[31:25];
  assign f7_zero    = (funct7 == 7'd0);
  assign f7_alt     = (funct7 == F7_ALT);

  // Sign-extended immediates
  assign imm_i = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
  assign imm_s = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:25], fetch_instr_i[11:7]};
  assign imm_u = {fetch_instr_i[31:12], 12'd0};

  // funct3 to ALU op, shared by OP and OP-IMM
  always_comb begin
    case (funct3)
      F3_SLL:  f3_op = ALU_SLL;
      F3_SLT:  f3_op = ALU_SLT;
      F3_SLTU: f3_op = ALU_SLTU;
      F3_XOR:  f3_op = ALU_XOR;
      F3_SR:   f3_op = f7_alt ? ALU_SRA : ALU_SRL;
      F3_OR:   f3_op = ALU_OR;
      F3_AND:  f3_op = ALU_AND;
      default: f3_op = ALU_ADD;
    endcase
  end

  always_comb begin
    op_d            = '0;
    op_d.alu_op     = f3_op;
    op_d.operand_a  = rs1_data_i;
    op_d.operand_b  = rs2_data_i;
    op_d.store_data = rs2_data_i;
    op_d.rd         = rd;
    writes_rd       = 1'b0;
    case (opcode)
      OPC_LUI: begin
        op_d.alu_op    = ALU_ADD;
        op_d.operand_a = '0;
        op_d.operand_b = imm_u;
        writes_rd      = 1'b1;
      end
      OPC_OP_IMM: begin
        op_d.operand_b = imm_i;
        // Shift immediates carry funct7 in the upper bits
        if (funct3 == F3_SLL) begin
          writes_rd = f7_zero;
        end else if (funct3 == F3_SR) begin
          writes_rd = f7_zero || f7_alt;
        end else begin
          writes_rd = 1'b1;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD_SUB && f7_alt) begin
          op_d.alu_op = ALU_SUB;
        end
        writes_rd = f7_zero || (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
      end
      OPC_STORE: begin
        // Address through the adder, rs2 as payload
        op_d.alu_op    = ALU_ADD;
        op_d.operand_b = imm_s;
        op_d.is_store  = (funct3 == F3_SW);
      end
      default: ;
    endcase
    // x0 and unknown encodings write nothing
    op_d.rd_we = writes_rd && (rd != '0);
  end

  //////////////////////////////
  // Execute slot
  //////////////////////////////

  assign decode_ready_o = !valid_q || ex_ready_i;
  assign ex_valid_o     = valid_q;
  assign ex_op_o        = op_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (decode_ready_o) begin
      valid_q <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid_i && decode_ready_o) begin
      op_q <= op_d;
    end
  end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_isa_pkg::*; import core_pkg::*; (
  input  logic   clk,
  input  logic   rst_ni,
  // Instruction memory port
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  // To decode
  output logic   fetch_valid_o,
  output instr_t fetch_instr_o,
  input  logic   decode_ready_i
);

  fetch_state_e state_q, state_d;
  addr_t        pc_q;
  instr_t       buf_q;

  // Request/grant/response sequence
  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b0;
    case (state_q)
      FETCH_REQ: begin
        instr_req_o = 1'b1;
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_HOLD;
        end
      end
      FETCH_HOLD: begin
        // Buffer drains this cycle so the next request may go out
        if (decode_ready_i) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? FETCH_WAIT : FETCH_REQ;
        end
      end
      default: state_d = FETCH_REQ;
    endcase
  end

  assign instr_addr_o  = pc_q;
  assign fetch_valid_o = (state_q == FETCH_HOLD);
  assign fetch_instr_o = buf_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FETCH_REQ;
      pc_q    <= BOOT_ADDR;
    end else begin
      state_q <= state_d;
      // Step on every accepted request
      if (instr_req_o && instr_gnt_i) begin
        pc_q <= pc_q + INSTR_BYTES;
      end
    end
  end

  // One word buffer, filled on the response
  always_ff @(posedge clk) begin
    if (state_q == FETCH_WAIT && instr_rvalid_i) begin
      buf_q <= instr_rdata_i;
    end
  end

endmodule

// File: logic/core_pkg.sv
package core_pkg;

  import rv_isa_pkg::*;

  //////////////////////////////
  // Datapath widths
  //////////////////////////////

  // One data word of the integer datapath
  typedef logic [31:0] word_t;

  // Byte address on the instruction and data ports
  typedef logic [31:0] addr_t;

  // First fetch address after reset
  localparam addr_t BOOT_ADDR = 32'h0000_0000;

  // PC step, no compressed instructions
  localparam addr_t INSTR_BYTES = 32'd4;

  //////////////////////////////
  // Execute stage types
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // Decoded operation held between decode and execute
  typedef struct packed {
    alu_op_e   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    word_t     store_data;
    reg_addr_t rd;
    logic      rd_we;
    logic      is_store;
  } ex_op_t;

  // Fetch FSM
  typedef enum logic [1:0] {FETCH_REQ, FETCH_WAIT, FETCH_HOLD} fetch_state_e;

  // Store FSM on the data port
  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} store_state_e;

endpackage

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

  //////////////////////////////
  // Instruction field types
  //////////////////////////////

  // Raw 32 bit instruction word
  typedef logic [31:0] instr_t;

  // Index into the integer register file
  typedef logic [4:0] reg_addr_t;

  // Major opcode, bits 6:0 of the instruction
  typedef logic [6:0] opcode_t;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_STORE  = 7'b0100011;

  // funct3 encodings for the OP and OP-IMM groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Word store, the only store width kept
  localparam logic [2:0] F3_SW = 3'b010;

  // Alternate funct7, picks SUB and SRA/SRAI
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // ADDI x0, x0, 0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

endpackage
